// File: source/karatsuba_consts.svh
// Widths are fixed by the Karatsuba recursion tree; only an 8-bit unsigned operand is supported
`ifndef KARATSUBA_CONSTS_SVH
`define KARATSUBA_CONSTS_SVH

// Width of each unsigned operand
// The split below assumes 8, then 4, then 2 bits
`define KARATSUBA_OPERAND_W 8

// Opaque label carried next to every operand pair
`define KARATSUBA_TAG_W 4

// Full product width
`define KARATSUBA_PRODUCT_W (2 * `KARATSUBA_OPERAND_W)

// Register stages inside the multiplier pipeline
// The operand capture register adds one more cycle in front
`define KARATSUBA_PIPE_STAGES 2

`endif

// File: source/karatsuba_arith_pkg.sv
// Unsigned arithmetic widths of the fixed 8-bit Karatsuba tree; other widths are not supported
`include "karatsuba_consts.svh"

package karatsuba_arith_pkg;

    // One input operand
    typedef logic [`KARATSUBA_OPERAND_W-1:0] operand_t;

    // Upper or lower half of an operand
    typedef logic [`KARATSUBA_OPERAND_W/2-1:0] half_t;

    // Sum of both halves, one carry bit wider
    typedef logic [`KARATSUBA_OPERAND_W/2:0] half_sum_t;

    // Product of two halves
    typedef logic [`KARATSUBA_OPERAND_W-1:0] half_prod_t;

    // Product of two half sums, 5 x 5 bits
    typedef logic [`KARATSUBA_OPERAND_W+1:0] mid_prod_t;

    // Full 16-bit result
    typedef logic [`KARATSUBA_PRODUCT_W-1:0] product_t;

endpackage

// File: source/karatsuba_stream_pkg.sv
// Stream-side types; the tag is opaque and returned unchanged, no other side-band signal exists
`include "karatsuba_consts.svh"

package karatsuba_stream_pkg;

    // Label returned with each product
    typedef logic [`KARATSUBA_TAG_W-1:0] tag_t;

    // Occupancy of one storage slot
    // FULL drives the valid of the stage that owns the slot
    typedef enum logic {
        SLOT_EMPTY = 1'b0,
        SLOT_FULL  = 1'b1
    } slot_state_t;

endpackage

// File: source/karatsuba_stream_if.sv
// Valid/ready streams; once valid is raised, valid and payload hold until the transfer
`timescale 1ns/100ps

interface operand_stream_if;
    import karatsuba_arith_pkg::*;
    import karatsuba_stream_pkg::*;

    logic     valid;
    logic     ready;
    operand_t operand_a;
    operand_t operand_b;
    tag_t     tag;

    modport source (
        output valid,
        output operand_a,
        output operand_b,
        output tag,
        input  ready
    );

    modport sink (
        input  valid,
        input  operand_a,
        input  operand_b,
        input  tag,
        output ready
    );

endinterface

interface product_stream_if;
    import karatsuba_arith_pkg::*;
    import karatsuba_stream_pkg::*;

    logic     valid;
    logic     ready;
    product_t product;
    tag_t     tag;

    modport source (
        output valid,
        output product,
        output tag,
        input  ready
    );

    modport sink (
        input  valid,
        input  product,
        input  tag,
        output ready
    );

endinterface

// File: source/operand_capture.sv
// One-entry input slot; in_ready depends combinationally on the downstream ready
`timescale 1ns/100ps

module operand_capture (
    input  logic                            aclk,
    input  logic                            aresetn,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  karatsuba_arith_pkg::operand_t   in_operand_a,
    input  karatsuba_arith_pkg::operand_t   in_operand_b,
    input  karatsuba_stream_pkg::tag_t      in_tag,
    operand_stream_if.source                dn
);
    import karatsuba_arith_pkg::*;
    import karatsuba_stream_pkg::*;

    slot_state_t state_q;
    operand_t    operand_a_q;
    operand_t    operand_b_q;
    tag_t        tag_q;

    logic take;
    logic drain;

    // Free now, or freed by the pipeline on this same edge
    assign in_ready = (state_q == SLOT_EMPTY) || dn.ready;

    assign take  = in_valid && in_ready;
    assign drain = dn.valid && dn.ready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state_q <= SLOT_EMPTY;
        end else if (take) begin
            // Refill wins over drain so back-to-back beats keep flowing
            state_q <= SLOT_FULL;
        end else if (drain) begin
            state_q <= SLOT_EMPTY;
        end
    end

    always_ff @(posedge aclk) begin
        if (take) begin
            operand_a_q <= in_operand_a;
            operand_b_q <= in_operand_b;
            tag_q       <= in_tag;
        end
    end

    assign dn.valid     = (state_q == SLOT_FULL);
    assign dn.operand_a = operand_a_q;
    assign dn.operand_b = operand_b_q;
    assign dn.tag       = tag_q;

endmodule

// File: source/karatsuba_mult4.sv
// Purely combinational 4 x 4 unsigned Karatsuba step; the 2-bit leaves are plain multiplies
`timescale 1ns/100ps

module karatsuba_mult4 (
    input  karatsuba_arith_pkg::half_t      operand_a,
    input  karatsuba_arith_pkg::half_t      operand_b,
    output karatsuba_arith_pkg::half_prod_t product
);
    logic [1:0] a_hi;
    logic [1:0] a_lo;
    logic [1:0] b_hi;
    logic [1:0] b_lo;
    logic [2:0] sum_a;
    logic [2:0] sum_b;
    logic [3:0] z0;
    logic [3:0] z2;
    logic [5:0] z1_full;
    logic [5:0] z1;

    assign a_hi = operand_a[3:2];
    assign a_lo = operand_a[1:0];
    assign b_hi = operand_b[3:2];
    assign b_lo = operand_b[1:0];

    assign z0 = {2'b00, a_lo} * {2'b00, b_lo};
    assign z2 = {2'b00, a_hi} * {2'b00, b_hi};

    assign sum_a = {1'b0, a_hi} + {1'b0, a_lo};
    assign sum_b = {1'b0, b_hi} + {1'b0, b_lo};

    // Up to 6 x 6, needs all six bits
    assign z1_full = {3'b000, sum_a} * {3'b000, sum_b};

    // Cross terms a_hi*b_lo + a_lo*b_hi
    assign z1 = z1_full - {2'b00, z2} - {2'b00, z0};

    assign product = {z2, 4'h0} + {z1, 2'b00} + {4'h0, z0};

endmodule

// File: source/karatsuba_pipe.sv
// Two register stages that advance together; a full last stage stalls everything behind it
`timescale 1ns/100ps
`include "karatsuba_consts.svh"

module karatsuba_pipe (
    input  logic              aclk,
    input  logic              aresetn,
    operand_stream_if.sink    up,
    product_stream_if.source  dn
);
    import karatsuba_arith_pkg::*;
    import karatsuba_stream_pkg::*;

    localparam int HALF_W = `KARATSUBA_OPERAND_W / 2;

    logic advance;

    // Stage 1 inputs
    half_t      a_hi;
    half_t      a_lo;
    half_t      b_hi;
    half_t      b_lo;
    half_sum_t  sum_a;
    half_sum_t  sum_b;
    half_prod_t low_prod;
    half_prod_t high_prod;
    mid_prod_t  mid_prod;

    // Stage 1 registers
    slot_state_t s1_state;
    half_prod_t  s1_low_q;
    half_prod_t  s1_high_q;
    mid_prod_t   s1_mid_q;
    tag_t        s1_tag_q;

    // Stage 2 combine and registers
    mid_prod_t   cross_term;
    product_t    combined;
    slot_state_t s2_state;
    product_t    s2_product_q;
    tag_t        s2_tag_q;

    // Whole pipe moves when the output slot is free or being read
    assign advance  = (s2_state == SLOT_EMPTY) || dn.ready;
    assign up.ready = advance;

    assign a_hi = up.operand_a[`KARATSUBA_OPERAND_W-1:HALF_W];
    assign a_lo = up.operand_a[HALF_W-1:0];
    assign b_hi = up.operand_b[`KARATSUBA_OPERAND_W-1:HALF_W];
    assign b_lo = up.operand_b[HALF_W-1:0];

    karatsuba_mult4 mult4_low_i (
        .operand_a (a_lo),
        .operand_b (b_lo),
        .product   (low_prod)
    );

    karatsuba_mult4 mult4_high_i (
        .operand_a (a_hi),
        .operand_b (b_hi),
        .product   (high_prod)
    );

    assign sum_a = {1'b0, a_hi} + {1'b0, a_lo};
    assign sum_b = {1'b0, b_hi} + {1'b0, b_lo};

    // Max 30 x 30, so ten bits
    assign mid_prod = {5'b00000, sum_a} * {5'b00000, sum_b};

    // Middle product minus both corner products leaves the cross terms
    assign cross_term = s1_mid_q - {2'b00, s1_high_q} - {2'b00, s1_low_q};

    assign combined = {s1_high_q, 8'h00}
                    + {2'b00, cross_term, 4'h0}
                    + {8'h00, s1_low_q};

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            s1_state <= SLOT_EMPTY;
            s2_state <= SLOT_EMPTY;
        end else if (advance) begin
            s1_state <= up.valid ? SLOT_FULL : SLOT_EMPTY;
            s2_state <= s1_state;
        end
    end

    always_ff @(posedge aclk) begin
        if (advance && up.valid) begin
            s1_low_q  <= low_prod;
            s1_high_q <= high_prod;
            s1_mid_q  <= mid_prod;
            s1_tag_q  <= up.tag;
        end
        if (advance && (s1_state == SLOT_FULL)) begin
            s2_product_q <= combined;
            s2_tag_q     <= s1_tag_q;
        end
    end

    assign dn.valid   = (s2_state == SLOT_FULL);
    assign dn.product = s2_product_q;
    assign dn.tag     = s2_tag_q;

endmodule

// File: source/karatsuba_mult_top.sv
// Streaming 8 x 8 unsigned multiplier, three cycles from input transfer to output, order kept
`timescale 1ns/100ps

module karatsuba_mult_top (
    input  logic                            aclk,
    input  logic                            aresetn,

    input  logic                            in_valid,
    output logic                            in_ready,
    input  karatsuba_arith_pkg::operand_t   in_operand_a,
    input  karatsuba_arith_pkg::operand_t   in_operand_b,
    input  karatsuba_stream_pkg::tag_t      in_tag,

    output logic                            out_valid,
    input  logic                            out_ready,
    output karatsuba_arith_pkg::product_t   out_product,
    output karatsuba_stream_pkg::tag_t      out_tag
);

    operand_stream_if operand_stream ();
    product_stream_if product_stream ();

    operand_capture operand_capture_i (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_operand_a (in_operand_a),
        .in_operand_b (in_operand_b),
        .in_tag       (in_tag),
        .dn           (operand_stream.source)
    );

    karatsuba_pipe karatsuba_pipe_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .up      (operand_stream.sink),
        .dn      (product_stream.source)
    );

    // Sink side of the product stream goes straight to the pins
    assign out_valid            = product_stream.valid;
    assign out_product          = product_stream.product;
    assign out_tag              = product_stream.tag;
    assign product_stream.ready = out_ready;

endmodule

// File: tb/tb_karatsuba_mult_top.sv
// Self-checking testbench; 4 ns clock, expected products are a*b kept in a queue in input order
`timescale 1ns/100ps
`include "karatsuba_consts.svh"

module tb_karatsuba_mult_top;
    import karatsuba_arith_pkg::*;
    import karatsuba_stream_pkg::*;

    localparam int TOTAL_BEATS     = 6 + 64 + 64 + 256 + 3;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 8 + 200;
    localparam int LATENCY         = `KARATSUBA_PIPE_STAGES + 1;
    localparam int DRAIN_CYCLES    = 100;

    logic     aclk;
    logic     aresetn;
    logic     in_valid;
    logic     in_ready;
    operand_t in_operand_a;
    operand_t in_operand_b;
    tag_t     in_tag;
    logic     out_valid;
    logic     out_ready;
    product_t out_product;
    tag_t     out_tag;

    integer   seed;
    int       error_count;
    int       pass_tests;
    int       fail_tests;
    logic     send_done;

    product_t exp_product_q[$];
    tag_t     exp_tag_q[$];

    // Output values held under back-pressure
    logic     held_valid;
    product_t held_product;
    tag_t     held_tag;

    karatsuba_mult_top karatsuba_mult_top_i (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_operand_a (in_operand_a),
        .in_operand_b (in_operand_b),
        .in_tag       (in_tag),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_product  (out_product),
        .out_tag      (out_tag)
    );

    always #2 aclk = ~aclk;

    task automatic compare_product(input string name, input product_t expected,
                                   input product_t actual);
        if (expected !== actual) begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_tag(input string name, input tag_t expected, input tag_t actual);
        if (expected !== actual) begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("ERROR at %0t: %s expected %b, got %b", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_latency(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            error_count++;
        end
    endtask

    // Scoreboard side, sampled on the edge where transfers happen
    always @(posedge aclk) begin : stream_monitor
        if (aresetn) begin
            if (held_valid) begin
                compare_flag("out_valid", 1'b1, out_valid);
                compare_product("out_product", held_product, out_product);
                compare_tag("out_tag", held_tag, out_tag);
            end
            if (in_valid && in_ready) begin
                exp_product_q.push_back({8'h00, in_operand_a} * {8'h00, in_operand_b});
                exp_tag_q.push_back(in_tag);
            end
            if (out_valid && out_ready) begin
                if (exp_product_q.size() == 0) begin
                    $display("Unexpected output at %0t with nothing pending", $time);
                    error_count++;
                end else begin
                    compare_product("out_product", exp_product_q.pop_front(), out_product);
                    compare_tag("out_tag", exp_tag_q.pop_front(), out_tag);
                end
            end
            held_valid   = out_valid && !out_ready;
            held_product = out_product;
            held_tag     = out_tag;
        end else begin
            held_valid = 1'b0;
        end
    end

    // Entered and left 1 ns after a rising edge
    task automatic send_beat(input operand_t a, input operand_t b, input tag_t t);
        in_valid     = 1'b1;
        in_operand_a = a;
        in_operand_b = b;
        in_tag       = t;
        do begin
            @(posedge aclk);
        end while (!in_ready);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_product_q.size() != 0 && cycles < DRAIN_CYCLES) begin
            @(posedge aclk);
            #1;
            cycles++;
        end
        if (exp_product_q.size() != 0) begin
            $display("Products missing at %0t: %0d never came out", $time, exp_product_q.size());
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_tests++;
            $display("PASS %s", name);
        end else begin
            fail_tests++;
            $display("FAIL %s with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic test_reset_state();
        int errors_before;
        errors_before = error_count;
        compare_flag("out_valid", 1'b0, out_valid);
        compare_flag("in_ready", 1'b1, in_ready);
        finish_test("reset_state", errors_before);
    endtask

    task automatic test_corner_products();
        int       errors_before;
        int       cycles;
        operand_t a_list[6];
        operand_t b_list[6];
        errors_before = error_count;
        a_list = '{8'd0, 8'd0, 8'd255, 8'd15, 8'd240, 8'd136};
        b_list = '{8'd0, 8'd255, 8'd255, 8'd17, 8'd15, 8'd136};
        out_ready = 1'b1;
        for (int i = 0; i < 6; i++) begin
            send_beat(a_list[i], b_list[i], tag_t'(i + 9));
            cycles = 0;
            do begin
                @(posedge aclk);
                cycles++;
            end while (!out_valid && cycles < 20);
            #1;
            if (!out_valid && exp_product_q.size() != 0) begin
                $display("No output for corner pair %0d within 20 cycles", i);
                error_count++;
            end else begin
                compare_latency("latency", LATENCY, cycles);
            end
            wait_drain();
        end
        finish_test("corner_products", errors_before);
    endtask

    task automatic test_back_to_back();
        int     errors_before;
        integer r;
        errors_before = error_count;
        out_ready = 1'b1;
        for (int i = 0; i < 64; i++) begin
            r = $random(seed);
            compare_flag("in_ready", 1'b1, in_ready);
            send_beat(r[7:0], r[15:8], r[19:16]);
        end
        wait_drain();
        finish_test("back_to_back", errors_before);
    endtask

    task automatic test_back_pressure();
        int     errors_before;
        integer r;
        logic [19:0] beats[64];
        errors_before = error_count;
        for (int i = 0; i < 64; i++) begin
            r = $random(seed);
            beats[i] = r[19:0];
        end
        send_done = 1'b0;
        fork
            begin
                for (int i = 0; i < 64; i++) begin
                    send_beat(beats[i][7:0], beats[i][15:8], beats[i][19:16]);
                end
                send_done = 1'b1;
            end
            begin
                r = $random(seed);
                out_ready = r[0];
                @(posedge aclk);
                // Sender flags completion 1 ns after an edge, so look on the edge
                while (!send_done) begin
                    #1;
                    r = $random(seed);
                    out_ready = r[0];
                    @(posedge aclk);
                end
                #1;
            end
        join
        out_ready = 1'b1;
        wait_drain();
        // Three beats fill the capture slot and both stages
        out_ready = 1'b0;
        for (int i = 0; i < 3; i++) begin
            send_beat(operand_t'(i + 3), 8'hc3, tag_t'(i));
        end
        compare_flag("in_ready", 1'b0, in_ready);
        compare_flag("out_valid", 1'b1, out_valid);
        repeat (2) @(posedge aclk);
        #1;
        compare_flag("in_ready", 1'b0, in_ready);
        out_ready = 1'b1;
        wait_drain();
        finish_test("back_pressure", errors_before);
    endtask

    task automatic test_sweep();
        int       errors_before;
        integer   r;
        operand_t a;
        errors_before = error_count;
        out_ready = 1'b1;
        for (int i = 0; i < 256; i++) begin
            r = $random(seed);
            repeat (r & 3) begin
                @(posedge aclk);
                #1;
            end
            a = operand_t'(i);
            send_beat(a, a ^ 8'ha5, a[3:0]);
        end
        wait_drain();
        finish_test("sweep", errors_before);
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin
        seed         = 32'h65ac_a074;
        aclk         = 1'b0;
        aresetn      = 1'b0;
        in_valid     = 1'b0;
        in_operand_a = '0;
        in_operand_b = '0;
        in_tag       = '0;
        out_ready    = 1'b1;
        send_done    = 1'b0;
        held_valid   = 1'b0;
        error_count  = 0;
        pass_tests   = 0;
        fail_tests   = 0;
        repeat (3) @(posedge aclk);
        #1;
        aresetn = 1'b1;

        test_reset_state();
        test_corner_products();
        test_back_to_back();
        test_back_pressure();
        test_sweep();

        $display("Summary: %0d passed, %0d failed, %0d errors", pass_tests, fail_tests,
                 error_count);
        if (error_count == 0 && fail_tests == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: karatsuba_mult_top.f
+incdir+source
source/karatsuba_arith_pkg.sv
source/karatsuba_stream_pkg.sv
source/karatsuba_stream_if.sv
source/operand_capture.sv
source/karatsuba_mult4.sv
source/karatsuba_pipe.sv
source/karatsuba_mult_top.sv
tb/tb_karatsuba_mult_top.sv

// File: Makefile
# Verilator build and run for the streaming Karatsuba multiplier

VERILATOR ?= verilator
TOP       ?= tb_karatsuba_mult_top
FILELIST  ?= karatsuba_mult_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps
PASS_TEXT ?= all tests passed

# Sources come from the file list, header folders are dropped
SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HDRS := $(wildcard source/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-o V$(TOP) -f $(FILELIST)

# Status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fxq "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
